// ==== verilog/exu_pkg.sv ====
// execution stage shared widths, opcodes, instruction views and channel types
package exu_pkg;

  localparam int XLEN    = 32;
  localparam int RFIDX_W = 5;
  localparam int ITAG_W  = 2;
  localparam int INSTR_W = 32;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [RFIDX_W-1:0] rs2;
    logic [RFIDX_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [RFIDX_W-1:0] rd;
    logic [6:0]         opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0]        imm12;
    logic [RFIDX_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [RFIDX_W-1:0] rd;
    logic [6:0]         opcode;
  } instr_i_t;

  // one instruction word, two decodings
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  typedef struct packed {
    alu_op_e            alu_op;
    logic               use_imm;
    logic               is_load;
    logic               rs1en;
    logic               rs2en;
    logic               rdwen;
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    imm;
  } dec_info_t;

  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [ITAG_W-1:0] itag;
  } lsu_cmd_t;

  typedef struct packed {
    logic [XLEN-1:0]   rdata;
    logic [ITAG_W-1:0] itag;
  } lsu_rsp_t;

  typedef struct packed {
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    wdat;
  } wbck_t;

endpackage

// ==== verilog/exu_regfile.sv ====
// integer register file, two combinational read ports and one write port
`timescale 1ns/1ps

module exu_regfile (
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs1idx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs2idx,
  output logic [exu_pkg::XLEN-1:0]    o_rs1,
  output logic [exu_pkg::XLEN-1:0]    o_rs2,
  input  logic                        i_wen,
  input  exu_pkg::wbck_t              i_wbck,
  input  logic                        clk,
  input  logic                        i_rst_n
);

  // x0 has no storage
  logic [exu_pkg::XLEN-1:0] rf_q [1:31];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 1; k < 32; k++) begin
        rf_q[k] <= '0;
      end
    end else if (i_wen && (i_wbck.rdidx != '0)) begin
      rf_q[i_wbck.rdidx] <= i_wbck.wdat;
    end
  end

  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

// ==== verilog/exu_decode.sv ====
// rv32i subset decoder producing the info bus and sign-extended immediate
`timescale 1ns/1ps

module exu_decode (
  input  exu_pkg::instr_u    i_instr,
  output exu_pkg::dec_info_t o_info
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       sel_op;
  logic       sel_op_imm;
  logic       sel_load;
  logic       known_f3;

  assign funct3     = i_instr.r.funct3;
  assign funct7     = i_instr.r.funct7;
  assign sel_op     = (i_instr.r.opcode == exu_pkg::OPC_OP);
  assign sel_op_imm = (i_instr.i.opcode == exu_pkg::OPC_OP_IMM);
  assign sel_load   = (i_instr.i.opcode == exu_pkg::OPC_LOAD) && (funct3 == 3'b010);

  // funct3 codes shared by the register and immediate forms
  assign known_f3 = (funct3 == 3'b000) || (funct3 == 3'b100) ||
                    (funct3 == 3'b110) || (funct3 == 3'b111);

  always_comb begin
    o_info         = '0;
    o_info.rdidx   = i_instr.r.rd;
    o_info.imm     = {{(exu_pkg::XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
    case (funct3)
      3'b100:  o_info.alu_op = exu_pkg::ALU_XOR;
      3'b110:  o_info.alu_op = exu_pkg::ALU_OR;
      3'b111:  o_info.alu_op = exu_pkg::ALU_AND;
      default: o_info.alu_op = exu_pkg::ALU_ADD;
    endcase
    if (sel_op && known_f3 && (funct7 == 7'b0000000)) begin
      o_info.rs1en = 1'b1;
      o_info.rs2en = 1'b1;
      o_info.rdwen = 1'b1;
    end else if (sel_op && (funct3 == 3'b000) && (funct7 == 7'b0100000)) begin
      o_info.alu_op = exu_pkg::ALU_SUB;
      o_info.rs1en  = 1'b1;
      o_info.rs2en  = 1'b1;
      o_info.rdwen  = 1'b1;
    end else if (sel_op_imm && known_f3) begin
      o_info.use_imm = 1'b1;
      o_info.rs1en   = 1'b1;
      o_info.rdwen   = 1'b1;
    end else if (sel_load) begin
      o_info.use_imm = 1'b1;
      o_info.is_load = 1'b1;
      o_info.rs1en   = 1'b1;
      o_info.rdwen   = 1'b1;
    end
    // x0 never creates a dependency
    if (i_instr.r.rs1 == '0) o_info.rs1en = 1'b0;
    if (i_instr.r.rs2 == '0) o_info.rs2en = 1'b0;
    if (i_instr.r.rd == '0) o_info.rdwen = 1'b0;
  end

endmodule

// ==== verilog/exu_oitf.sv ====
// outstanding instruction track FIFO for long-pipe loads
`timescale 1ns/1ps

module exu_oitf #(
  parameter int OITF_DEPTH = 4
) (
  input  logic                        i_dis_ena,
  input  logic [exu_pkg::RFIDX_W-1:0] i_dis_rdidx,
  output logic [exu_pkg::ITAG_W-1:0]  o_dis_ptr,
  output logic                        o_full,
  input  logic                        i_ret_ena,
  output logic [exu_pkg::RFIDX_W-1:0] o_ret_rdidx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs1idx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs2idx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rdidx,
  input  logic                        i_rs1en,
  input  logic                        i_rs2en,
  input  logic                        i_rdwen,
  output logic                        o_match,
  input  logic                        clk,
  input  logic                        i_rst_n
);

  logic [exu_pkg::ITAG_W-1:0]  wr_ptr_q;
  logic [exu_pkg::ITAG_W-1:0]  rd_ptr_q;
  logic [OITF_DEPTH-1:0]       vld_q;
  logic [exu_pkg::RFIDX_W-1:0] rdidx_q [OITF_DEPTH];

  // wraps at the depth, not at the pointer width
  function automatic logic [exu_pkg::ITAG_W-1:0] ptr_inc(
    input logic [exu_pkg::ITAG_W-1:0] ptr
  );
    if (ptr == exu_pkg::ITAG_W'(OITF_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////
  // pointers and valid bits
  //////////////////////////////
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      vld_q    <= '0;
    end else begin
      if (i_dis_ena) begin
        vld_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q        <= ptr_inc(wr_ptr_q);
      end
      if (i_ret_ena) begin
        vld_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q        <= ptr_inc(rd_ptr_q);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_dis_ena) begin
      rdidx_q[wr_ptr_q] <= i_dis_rdidx;
    end
  end

  // the slot under the write pointer still busy means no room
  assign o_full      = vld_q[wr_ptr_q];
  assign o_dis_ptr   = wr_ptr_q;
  assign o_ret_rdidx = rdidx_q[rd_ptr_q];

  // RAW and WAW check against every live entry
  always_comb begin
    o_match = 1'b0;
    for (int k = 0; k < OITF_DEPTH; k++) begin
      if (vld_q[k] && ((i_rs1en && (rdidx_q[k] == i_rs1idx)) ||
                       (i_rs2en && (rdidx_q[k] == i_rs2idx)) ||
                       (i_rdwen && (rdidx_q[k] == i_rdidx)))) begin
        o_match = 1'b1;
      end
    end
  end

endmodule

// ==== verilog/exu_disp.sv ====
// dispatch, hazard stall and routing of one instruction to ALU or load command
`timescale 1ns/1ps

module exu_disp (
  input  logic               i_valid,
  output logic               o_ready,
  input  exu_pkg::dec_info_t i_info,
  input  logic               i_oitf_full,
  input  logic               i_oitf_match,
  input  logic               i_lsu_cmd_ready,
  input  logic               i_alu_wbck_busy,
  output logic               o_alu_fire,
  output logic               o_load_fire,
  output logic               o_lsu_cmd_valid
);

  logic load_can_go;
  logic alu_can_go;

  // a load needs an OITF slot and no pending dependency
  assign load_can_go = ~i_oitf_match & ~i_oitf_full;

  // everything else writes in this cycle, so it needs the write port
  assign alu_can_go = ~i_oitf_match & ~i_alu_wbck_busy;

  // command valid is independent of command ready
  assign o_lsu_cmd_valid = i_valid & i_info.is_load & load_can_go;

  assign o_ready = i_info.is_load ? (load_can_go & i_lsu_cmd_ready) : alu_can_go;

  assign o_load_fire = o_lsu_cmd_valid & i_lsu_cmd_ready;
  assign o_alu_fire  = i_valid & ~i_info.is_load & alu_can_go;

endmodule

// ==== verilog/exu_alu.sv ====
// integer ALU, also forms the load address
`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::dec_info_t       i_info,
  input  logic [exu_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_pkg::XLEN-1:0] i_rs2,
  output logic [exu_pkg::XLEN-1:0] o_result
);

  logic [exu_pkg::XLEN-1:0] op2;
  exu_pkg::alu_op_e         op;

  // loads always add the offset to rs1
  assign op2 = (i_info.use_imm | i_info.is_load) ? i_info.imm : i_rs2;
  assign op  = i_info.is_load ? exu_pkg::ALU_ADD : i_info.alu_op;

  always_comb begin
    case (op)
      exu_pkg::ALU_SUB: o_result = i_rs1 - op2;
      exu_pkg::ALU_AND: o_result = i_rs1 & op2;
      exu_pkg::ALU_OR:  o_result = i_rs1 | op2;
      exu_pkg::ALU_XOR: o_result = i_rs1 ^ op2;
      default:          o_result = i_rs1 + op2;
    endcase
  end

endmodule

// ==== verilog/exu_wbck.sv ====
// final write-back arbiter, long pipe over ALU, onto the register file port
`timescale 1ns/1ps

module exu_wbck (
  input  logic                        i_alu_valid,
  input  logic [exu_pkg::RFIDX_W-1:0] i_alu_rdidx,
  input  logic [exu_pkg::XLEN-1:0]    i_alu_wdat,
  input  logic                        i_longp_valid,
  input  logic [exu_pkg::RFIDX_W-1:0] i_longp_rdidx,
  input  logic [exu_pkg::XLEN-1:0]    i_longp_wdat,
  output logic                        o_alu_busy,
  output logic                        o_wen,
  output exu_pkg::wbck_t              o_wbck
);

  // fixed priority, returning loads win
  assign o_alu_busy = i_longp_valid;

  assign o_wbck.rdidx = i_longp_valid ? i_longp_rdidx : i_alu_rdidx;
  assign o_wbck.wdat  = i_longp_valid ? i_longp_wdat : i_alu_wdat;

  // x0 writes vanish here
  assign o_wen = (i_longp_valid | i_alu_valid) & (o_wbck.rdidx != '0);

endmodule

// ==== verilog/exu_top.sv ====
// execution stage top level, regfile, decode, dispatch, OITF, ALU and write-back
`timescale 1ns/1ps

module exu_top #(
  parameter int OITF_DEPTH = 4
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_valid,
  input  exu_pkg::instr_u   i_instr,
  output logic              o_ready,
  output logic              o_lsu_cmd_valid,
  output exu_pkg::lsu_cmd_t o_lsu_cmd,
  input  logic              i_lsu_cmd_ready,
  input  logic              i_lsu_rsp_valid,
  input  exu_pkg::lsu_rsp_t i_lsu_rsp,
  output logic              o_lsu_rsp_ready,
  output logic              o_wbck_valid,
  output exu_pkg::wbck_t    o_wbck
);

  logic [exu_pkg::XLEN-1:0]    rf_rs1;
  logic [exu_pkg::XLEN-1:0]    rf_rs2;
  exu_pkg::dec_info_t          dec_info;
  logic [exu_pkg::ITAG_W-1:0]  oitf_dis_ptr;
  logic [exu_pkg::RFIDX_W-1:0] oitf_ret_rdidx;
  logic                        oitf_full;
  logic                        oitf_match;
  logic                        alu_fire;
  logic                        load_fire;
  logic                        alu_busy;
  logic [exu_pkg::XLEN-1:0]    alu_result;
  logic                        rsp_ready_q;
  logic                        rsp_fire;

  // response side opens one cycle out of reset and stays open
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_ready_q <= 1'b0;
    end else begin
      rsp_ready_q <= 1'b1;
    end
  end

  assign o_lsu_rsp_ready = rsp_ready_q;
  assign rsp_fire        = i_lsu_rsp_valid & rsp_ready_q;

  //////////////////////////////
  // operand read and decode
  //////////////////////////////
  exu_regfile u_regfile (
    .i_rs1idx (i_instr.r.rs1),
    .i_rs2idx (i_instr.r.rs2),
    .o_rs1    (rf_rs1),
    .o_rs2    (rf_rs2),
    .i_wen    (o_wbck_valid),
    .i_wbck   (o_wbck),
    .clk      (clk),
    .i_rst_n  (i_rst_n)
  );

  exu_decode u_decode (
    .i_instr (i_instr),
    .o_info  (dec_info)
  );

  //////////////////////////////
  // hazard tracking and dispatch
  //////////////////////////////
  exu_oitf #(
    .OITF_DEPTH (OITF_DEPTH)
  ) u_oitf (
    .i_dis_ena   (load_fire),
    .i_dis_rdidx (dec_info.rdidx),
    .o_dis_ptr   (oitf_dis_ptr),
    .o_full      (oitf_full),
    .i_ret_ena   (rsp_fire),
    .o_ret_rdidx (oitf_ret_rdidx),
    .i_rs1idx    (i_instr.r.rs1),
    .i_rs2idx    (i_instr.r.rs2),
    .i_rdidx     (dec_info.rdidx),
    .i_rs1en     (dec_info.rs1en),
    .i_rs2en     (dec_info.rs2en),
    .i_rdwen     (dec_info.rdwen),
    .o_match     (oitf_match),
    .clk         (clk),
    .i_rst_n     (i_rst_n)
  );

  exu_disp u_disp (
    .i_valid         (i_valid),
    .o_ready         (o_ready),
    .i_info          (dec_info),
    .i_oitf_full     (oitf_full),
    .i_oitf_match    (oitf_match),
    .i_lsu_cmd_ready (i_lsu_cmd_ready),
    .i_alu_wbck_busy (alu_busy),
    .o_alu_fire      (alu_fire),
    .o_load_fire     (load_fire),
    .o_lsu_cmd_valid (o_lsu_cmd_valid)
  );

  exu_alu u_alu (
    .i_info   (dec_info),
    .i_rs1    (rf_rs1),
    .i_rs2    (rf_rs2),
    .o_result (alu_result)
  );

  // load command carries the OITF slot as its tag
  assign o_lsu_cmd.addr = alu_result;
  assign o_lsu_cmd.itag = oitf_dis_ptr;

  exu_wbck u_wbck (
    .i_alu_valid   (alu_fire & dec_info.rdwen),
    .i_alu_rdidx   (dec_info.rdidx),
    .i_alu_wdat    (alu_result),
    .i_longp_valid (rsp_fire),
    .i_longp_rdidx (oitf_ret_rdidx),
    .i_longp_wdat  (i_lsu_rsp.rdata),
    .o_alu_busy    (alu_busy),
    .o_wen         (o_wbck_valid),
    .o_wbck        (o_wbck)
  );

endmodule

// ==== sim/tb_exu.sv ====
// execution stage testbench driving a random instruction stream against a shadow model
`timescale 1ns/1ps

module tb_exu;

  localparam int OITF_DEPTH = 4;
  localparam int N_INSTR    = 200;
  localparam int CLK_PERIOD = 8;
  localparam int KIND_NONE  = 0;
  localparam int KIND_ALU   = 1;
  localparam int KIND_LOAD  = 2;

  typedef struct packed {
    logic [exu_pkg::RFIDX_W-1:0] rd;
    logic [exu_pkg::XLEN-1:0]    addr;
  } ld_exp_t;

  logic              clk;
  logic              i_rst_n;
  logic              i_valid;
  exu_pkg::instr_u   i_instr;
  logic              o_ready;
  logic              o_lsu_cmd_valid;
  exu_pkg::lsu_cmd_t o_lsu_cmd;
  logic              i_lsu_cmd_ready;
  logic              i_lsu_rsp_valid;
  exu_pkg::lsu_rsp_t i_lsu_rsp;
  logic              o_lsu_rsp_ready;
  logic              o_wbck_valid;
  exu_pkg::wbck_t    o_wbck;

  integer            seed = 32'h5c21;
  logic [31:0]       shadow [32];
  logic              pending [32];
  ld_exp_t           ld_q [$];
  exu_pkg::lsu_cmd_t mem_q [$];
  int                n_issued;
  int                n_acc;
  int                load_count;
  int                cmd_count;
  int                tag_exp;
  int                rsp_wait;
  int                stall_left;
  logic              accepted;
  logic              rsp_done;

  exu_top #(
    .OITF_DEPTH (OITF_DEPTH)
  ) DUT (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_valid         (i_valid),
    .i_instr         (i_instr),
    .o_ready         (o_ready),
    .o_lsu_cmd_valid (o_lsu_cmd_valid),
    .o_lsu_cmd       (o_lsu_cmd),
    .i_lsu_cmd_ready (i_lsu_cmd_ready),
    .i_lsu_rsp_valid (i_lsu_rsp_valid),
    .i_lsu_rsp       (i_lsu_rsp),
    .o_lsu_rsp_ready (o_lsu_rsp_ready),
    .o_wbck_valid    (o_wbck_valid),
    .o_wbck          (o_wbck)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'hA5A5_0000;
    return {x[28:0], x[31:29]};
  endfunction

  function automatic int instr_kind(input exu_pkg::instr_u ins);
    logic f3_ok;
    f3_ok = ins.r.funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};
    case (ins.r.opcode)
      exu_pkg::OPC_OP: begin
        if ((ins.r.funct7 == 7'b0000000) && f3_ok) return KIND_ALU;
        if ((ins.r.funct7 == 7'b0100000) && (ins.r.funct3 == 3'b000)) return KIND_ALU;
      end
      exu_pkg::OPC_OP_IMM: begin
        if (f3_ok) return KIND_ALU;
      end
      exu_pkg::OPC_LOAD: begin
        if (ins.i.funct3 == 3'b010) return KIND_LOAD;
      end
      default: ;
    endcase
    return KIND_NONE;
  endfunction

  // ALU result or load address from shadow operands
  function automatic logic [31:0] ref_exec(input exu_pkg::instr_u ins, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [31:0] imm;
    logic [31:0] op2;
    imm = {{20{ins.i.imm12[11]}}, ins.i.imm12};
    op2 = (ins.r.opcode == exu_pkg::OPC_OP) ? b : imm;
    case (ins.r.funct3)
      3'b100:  return a ^ op2;
      3'b110:  return a | op2;
      3'b111:  return a & op2;
      default: return ((ins.r.opcode == exu_pkg::OPC_OP) && ins.r.funct7[5]) ? a - op2 : a + op2;
    endcase
  endfunction

  //////////////////////////////
  // checks
  //////////////////////////////
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_wbck(input logic exp_v, input exu_pkg::wbck_t exp);
    if (o_wbck_valid !== exp_v) begin
      abort_run($sformatf("[ERROR] %0t: write-back valid %b, expected %b",
                          $time, o_wbck_valid, exp_v));
    end else if (exp_v && (o_wbck !== exp)) begin
      abort_run($sformatf("[ERROR] %0t: write-back x%0d=%h, expected x%0d=%h",
                          $time, o_wbck.rdidx, o_wbck.wdat, exp.rdidx, exp.wdat));
    end
  endtask

  task automatic check_cmd(input exu_pkg::lsu_cmd_t exp);
    if (!(o_lsu_cmd_valid && i_lsu_cmd_ready)) begin
      abort_run("a load was accepted without a command handshake");
    end else if (o_lsu_cmd !== exp) begin
      abort_run($sformatf("[ERROR] %0t: load command addr %h tag %0d, expected addr %h tag %0d",
                          $time, o_lsu_cmd.addr, o_lsu_cmd.itag, exp.addr, exp.itag));
    end
  endtask

  // expected events of one cycle sampled at the falling edge
  task automatic score_cycle();
    logic              exp_v;
    exu_pkg::wbck_t    exp;
    exu_pkg::lsu_cmd_t cmd;
    ld_exp_t           ld;
    int                kind;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic [31:0]       res;
    exp_v    = 1'b0;
    exp      = '0;
    rs1      = i_instr.r.rs1;
    rs2      = i_instr.r.rs2;
    rd       = i_instr.r.rd;
    accepted = i_valid && o_ready;
    rsp_done = i_lsu_rsp_valid && o_lsu_rsp_ready;
    if (o_lsu_cmd_valid && i_lsu_cmd_ready) begin
      cmd_count++;
      mem_q.push_back(o_lsu_cmd);
    end
    if (accepted) begin
      kind = instr_kind(i_instr);
      res  = ref_exec(i_instr, shadow[rs1], shadow[rs2]);
      if ((kind != KIND_NONE) && (pending[rs1] || pending[rd] ||
          ((i_instr.r.opcode == exu_pkg::OPC_OP) && pending[rs2]))) begin
        abort_run($sformatf("[ERROR] %0t: instruction %h accepted ahead of a pending load",
                            $time, i_instr));
      end
      if ((kind != KIND_LOAD) && rsp_done) begin
        abort_run("a non-load instruction was accepted while a load response held the write port");
      end
      if ((kind == KIND_ALU) && (rd != 0)) begin
        exp_v      = 1'b1;
        exp.rdidx  = rd;
        exp.wdat   = res;
        shadow[rd] = res;
      end else if (kind == KIND_LOAD) begin
        if (ld_q.size() >= OITF_DEPTH) begin
          abort_run($sformatf("[ERROR] %0t: load accepted with %0d loads already in flight",
                              $time, ld_q.size()));
        end
        cmd.addr = res;
        cmd.itag = exu_pkg::ITAG_W'(tag_exp);
        check_cmd(cmd);
        tag_exp = (tag_exp + 1) % OITF_DEPTH;
        load_count++;
        ld.rd   = rd;
        ld.addr = res;
        ld_q.push_back(ld);
        if (rd != 0) begin
          pending[rd] = 1'b1;
          shadow[rd]  = mem_word(res);
        end
      end
      n_acc++;
    end
    if (rsp_done) begin
      if (ld_q.size() == 0) begin
        abort_run("a load response arrived with no load outstanding");
      end
      ld = ld_q.pop_front();
      void'(mem_q.pop_front());
      pending[ld.rd] = 1'b0;
      if (ld.rd != 0) begin
        exp_v     = 1'b1;
        exp.rdidx = ld.rd;
        exp.wdat  = mem_word(ld.addr);
      end
    end
    check_wbck(exp_v, exp);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic make_instr(input int n, output exu_pkg::instr_u ins);
    logic [31:0] r;
    logic [31:0] c;
    logic [2:0]  f3;
    r = $random(seed);
    c = $random(seed);
    ins       = r;
    ins.r.rd  = {2'b00, c[2:0]};
    ins.r.rs1 = {2'b00, c[5:3]};
    ins.r.rs2 = {2'b00, c[8:6]};
    case (c[10:9])
      2'd0:    f3 = 3'b000;
      2'd1:    f3 = 3'b100;
      2'd2:    f3 = 3'b110;
      default: f3 = 3'b111;
    endcase
    if ((n >= 60) && (n < 100)) begin
      // load burst into x8..x15 that overfills the OITF
      ins.i.opcode = exu_pkg::OPC_LOAD;
      ins.i.funct3 = 3'b010;
      ins.i.rd     = 5'(8 + n % 8);
    end else begin
      case (c[13:11])
        3'd0, 3'd1: begin
          ins.r.opcode = exu_pkg::OPC_OP;
          ins.r.funct3 = c[14] ? 3'b000 : f3;
          ins.r.funct7 = c[14] ? 7'b0100000 : 7'b0000000;
        end
        3'd2, 3'd3: begin
          ins.i.opcode = exu_pkg::OPC_OP_IMM;
          ins.i.funct3 = f3;
        end
        3'd4, 3'd5: begin
          ins.i.opcode = exu_pkg::OPC_LOAD;
          ins.i.funct3 = 3'b010;
        end
        3'd6: begin
          // SLL or a system opcode outside the subset
          ins.r.opcode = c[14] ? 7'b1110011 : exu_pkg::OPC_OP;
          ins.r.funct3 = 3'b001;
          ins.r.funct7 = 7'b0000000;
        end
        default: begin
          ins.i.opcode = exu_pkg::OPC_OP_IMM;
          ins.i.funct3 = f3;
          if (c[14]) ins.i.rd = '0;
          else ins.i.rs1 = '0;
        end
      endcase
    end
  endtask

  task automatic drive_inputs();
    logic [31:0]     r;
    exu_pkg::instr_u ins;
    r = $random(seed);
    // command ready with stretches held low
    if (stall_left > 0) begin
      i_lsu_cmd_ready = 1'b0;
      stall_left--;
    end else if (r[3:0] == 4'd0) begin
      i_lsu_cmd_ready = 1'b0;
      stall_left      = 2 + int'(r[5:4]);
    end else begin
      i_lsu_cmd_ready = r[6] | r[7];
    end
    // in-order memory responder with 0 to 5 cycles of delay
    if (rsp_done) begin
      i_lsu_rsp_valid = 1'b0;
      rsp_wait        = int'(r[10:8]) % 6;
    end
    if (!i_lsu_rsp_valid && (mem_q.size() > 0)) begin
      if (rsp_wait == 0) begin
        i_lsu_rsp_valid = 1'b1;
        i_lsu_rsp.rdata = mem_word(mem_q[0].addr);
        i_lsu_rsp.itag  = mem_q[0].itag;
      end else begin
        rsp_wait--;
      end
    end
    if (!i_valid || accepted) begin
      if ((n_issued < N_INSTR) && (r[14:12] != 3'd0)) begin
        make_instr(n_issued, ins);
        i_instr = ins;
        i_valid = 1'b1;
        n_issued++;
      end else begin
        i_valid = 1'b0;
      end
    end
  endtask

  always @(posedge clk) begin
    if (i_rst_n) begin
      #1;
      drive_inputs();
    end
  end

  always @(negedge clk) begin
    if (i_rst_n) begin
      score_cycle();
    end
  end

  initial begin
    #(N_INSTR * 20 * CLK_PERIOD);
    abort_run("watchdog expired before all instructions and loads completed");
  end

  initial begin
    clk             = 1'b0;
    i_rst_n         = 1'b0;
    i_valid         = 1'b0;
    i_instr         = '0;
    i_lsu_cmd_ready = 1'b0;
    i_lsu_rsp_valid = 1'b0;
    i_lsu_rsp       = '0;
    accepted        = 1'b0;
    rsp_done        = 1'b0;
    n_issued        = 0;
    n_acc           = 0;
    load_count      = 0;
    cmd_count       = 0;
    tag_exp         = 0;
    rsp_wait        = 0;
    stall_left      = 0;
    for (int k = 0; k < 32; k++) begin
      shadow[k]  = '0;
      pending[k] = 1'b0;
    end
    @(negedge clk);
    if (o_lsu_cmd_valid || o_lsu_rsp_ready || o_wbck_valid) begin
      abort_run("an output handshake was active during reset");
    end
    @(posedge clk);
    #1 i_rst_n = 1'b1;
    while (!((n_acc == N_INSTR) && (ld_q.size() == 0))) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if ((mem_q.size() != 0) || (cmd_count != load_count)) begin
      abort_run($sformatf("run ended with %0d load commands for %0d loads",
                          cmd_count, load_count));
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== all.f ====
verilog/exu_pkg.sv
verilog/exu_regfile.sv
verilog/exu_decode.sv
verilog/exu_oitf.sv
verilog/exu_disp.sv
verilog/exu_alu.sv
verilog/exu_wbck.sv
verilog/exu_top.sv
sim/tb_exu.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_exu -f all.f
	@out=$$(./obj_dir/Vtb_exu); echo "$$out"; echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir
